//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= conv_args_tb
FILELIST   ?= conv_args.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- conv_args.f
+incdir+design
design/conv_args_pkg.sv
design/args_word_ram.sv
design/args_mem_arbiter.sv
design/args_stream_fetch.sv
design/args_tile_sequencer.sv
design/conv_args_loader.sv
tb/conv_args_tb.sv

//--- design/args_mem_arbiter.sv
`default_nettype none
`include "conv_args_defines.svh"

module args_mem_arbiter
  import conv_args_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic [2:0]              req,
  input  wire mem_req_t                req_info [3],
  input  wire logic [`ARGS_WORD_W-1:0] rd_data,
  output logic [2:0]                   gnt,
  output logic                         rd_en,
  output logic [`ARGS_ADR_W-1:0]       rd_adr,
  output logic                         arg_valid,
  output arg_word_t                    arg_word
);

  logic [1:0] last_q;
  logic [1:0] sel;
  logic       valid_q;
  args_kind_e kind_q;
  mem_req_t   info_q;

  ////////////////////////////////////////
  // round-robin pick
  ////////////////////////////////////////

  // walk from the farthest slot to the nearest so the one right after last_q wins
  always_comb
  begin
    int idx;
    sel = last_q;
    for (int i = 3; i >= 1; i--)
    begin
      idx = (int'(last_q) + i) % 3;
      if (req[idx])
      begin
        sel = idx[1:0];
      end
    end
  end

  assign gnt    = (|req) ? (3'b001 << sel) : 3'b000;
  assign rd_en  = |req;
  assign rd_adr = req_info[sel].adr;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      last_q  <= 2'd2;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= |req;
      if (|req)
      begin
        last_q <= sel;
      end
    end
  end

  // tag and slot info ride alongside the read
  always_ff @(posedge clk)
  begin
    if (|req)
    begin
      kind_q <= args_kind_e'(sel);
      info_q <= req_info[sel];
    end
  end

  ////////////////////////////////////////
  // output record
  ////////////////////////////////////////

  assign arg_valid = valid_q;
  assign arg_word  = '{kind: kind_q, adr: info_q.adr, reg_start: info_q.reg_start,
                       reg_size: info_q.reg_size, data: rd_data};

  // a requester granted twice in a row means nobody else was waiting
  a_gnt_rr: assert property (@(posedge clk) disable iff (reset)
    |(gnt & $past(gnt)) |-> (req & ~gnt) == 3'b000);
  a_gnt_to_req: assert property (@(posedge clk) disable iff (reset) (gnt & ~req) == 3'b000);

endmodule

`default_nettype wire

//--- design/args_stream_fetch.sv
`default_nettype none
`include "conv_args_defines.svh"

module args_stream_fetch
  import conv_args_pkg::*;
#(
  parameter args_kind_e KIND          = KIND_BIAS,
  parameter int         PER_WORD_LOG2 = 6
) (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire layer_cfg_t cfg,
  input  wire tile_t      tile,
  input  wire logic       tile_go,
  input  wire logic       gnt,
  output logic            req,
  output mem_req_t        req_info,
  output logic            kind_done
);

  fetch_state_e           state_q;
  logic [`OF_W-1:0]       word_idx_q;
  logic [`SLOT_W-1:0]     reg_start_q;
  logic [`ARGS_ADR_W-1:0] base;
  logic [`OF_W-1:0]       per_word;
  logic [`OF_W-1:0]       consumed;
  logic [`OF_W-1:0]       remaining;
  logic [`OF_W-1:0]       args_n;
  logic                   last_word;
  int                     reg_shift;
  logic [`SLOT_W-1:0]     reg_size;

  ////////////////////////////////////////
  // address and slot math
  ////////////////////////////////////////

  always_comb
  begin
    case (KIND)
      KIND_TAIL: base = cfg.tail_base;
      KIND_RANK: base = cfg.rank_base;
      default:   base = cfg.bias_base;
    endcase
  end

  assign per_word  = `OF_W'(1) << PER_WORD_LOG2;
  assign consumed  = word_idx_q << PER_WORD_LOG2;
  assign remaining = tile.tile_size - consumed;
  assign last_word = (remaining <= per_word);

  // partial count only in the last word of a short tile
  assign args_n    = last_word ? remaining : per_word;
  assign reg_shift = cfg.mode ? `ARGS_PER_REG_LOG2_MODE1 : `ARGS_PER_REG_LOG2_MODE0;
  assign reg_size  = `SLOT_W'(args_n >> reg_shift);

  assign req       = (state_q == FETCH_RUN);
  assign kind_done = req && gnt && last_word;

  assign req_info = '{
    adr:       base + (tile.tof_start >> PER_WORD_LOG2) + word_idx_q,
    reg_start: reg_start_q,
    reg_size:  reg_size
  };

  ////////////////////////////////////////
  // word loop
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q     <= FETCH_IDLE;
      word_idx_q  <= '0;
      reg_start_q <= '0;
    end
    else
    begin
      case (state_q)
        FETCH_IDLE, FETCH_DONE:
        begin
          if (tile_go)
          begin
            state_q     <= FETCH_RUN;
            word_idx_q  <= '0;
            reg_start_q <= '0;
          end
          else
          begin
            state_q <= FETCH_IDLE;
          end
        end
        FETCH_RUN:
        begin
          // stall here while another kind owns the memory
          if (gnt)
          begin
            if (last_word)
            begin
              state_q <= FETCH_DONE;
            end
            word_idx_q  <= word_idx_q + 1'b1;
            reg_start_q <= reg_start_q + reg_size;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (reset)
    req && !gnt |=> req && $stable(req_info));

endmodule

`default_nettype wire

//--- design/args_tile_sequencer.sv
`default_nettype none
`include "conv_args_defines.svh"

module args_tile_sequencer
  import conv_args_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       args_refresh,
  input  wire layer_cfg_t cfg_in,
  input  wire logic [2:0] kind_done,
  output layer_cfg_t      cfg,
  output tile_t           tile,
  output logic            tile_go,
  output logic            busy,
  output logic            tile_done,
  output logic            layer_done
);

  seq_state_e       state_q;
  layer_cfg_t       cfg_q;
  logic [`OF_W-1:0] tof_q;
  logic [2:0]       done_q;
  logic             go_q;
  logic             tile_done_q;
  logic             layer_done_q;
  logic [`OF_W-1:0] rows;
  logic [`OF_W-1:0] remain;
  logic             start;
  logic             all_done;
  logic             last_tile;

  assign rows      = cfg_q.mode ? `OF_W'(`ROWS_MODE1) : `OF_W'(`ROWS_MODE0);
  assign remain    = cfg_q.of - tof_q;
  assign last_tile = ({1'b0, tof_q} + {1'b0, rows}) >= {1'b0, cfg_q.of};
  assign start     = args_refresh && (state_q == SEQ_IDLE);
  assign all_done  = (state_q == SEQ_BUSY) && (&(done_q | kind_done));

  // new config only at the head of a layer
  always_ff @(posedge clk)
  begin
    if (start && (tof_q == '0))
    begin
      cfg_q <= cfg_in;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q      <= SEQ_IDLE;
      tof_q        <= '0;
      done_q       <= '0;
      go_q         <= 1'b0;
      tile_done_q  <= 1'b0;
      layer_done_q <= 1'b0;
    end
    else
    begin
      go_q         <= start;
      tile_done_q  <= all_done;
      layer_done_q <= all_done && last_tile;
      if (start)
      begin
        state_q <= SEQ_BUSY;
        done_q  <= '0;
      end
      else if (all_done)
      begin
        state_q <= SEQ_IDLE;
        done_q  <= '0;
        tof_q   <= last_tile ? '0 : tof_q + rows;
      end
      else if (state_q == SEQ_BUSY)
      begin
        done_q <= done_q | kind_done;
      end
    end
  end

  assign cfg            = cfg_q;
  assign tile.tof_start = tof_q;
  assign tile.tile_size = (remain < rows) ? remain : rows;
  assign tile_go        = go_q;
  assign busy           = (state_q == SEQ_BUSY);
  assign tile_done      = tile_done_q;
  assign layer_done     = layer_done_q;

  // fetchers only finish inside a tile that was started here
  a_done_in_busy: assert property (@(posedge clk) disable iff (reset)
    |kind_done |-> state_q == SEQ_BUSY);

endmodule

`default_nettype wire

//--- design/args_word_ram.sv
`default_nettype none
`include "conv_args_defines.svh"

module args_word_ram (
  input  wire logic                   clk,
  input  wire logic                   wr_en,
  input  wire logic [`ARGS_ADR_W-1:0] wr_adr,
  input  wire logic [`ARGS_WORD_W-1:0] wr_data,
  input  wire logic                   rd_en,
  input  wire logic [`ARGS_ADR_W-1:0] rd_adr,
  output logic [`ARGS_WORD_W-1:0]     rd_data
);

  localparam int AW = $clog2(`ARGS_DEPTH);

  logic [`ARGS_WORD_W-1:0] mem [`ARGS_DEPTH];

  // preload port, written by the host side
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_adr[AW-1:0]] <= wr_data;
    end
  end

  // one-cycle read
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      rd_data <= mem[rd_adr[AW-1:0]];
    end
  end

  // preload and fetch must not collide on one word
  a_no_rw_collision: assert property (@(posedge clk)
    !(wr_en && rd_en && (wr_adr == rd_adr)));

endmodule

`default_nettype wire

//--- design/conv_args_defines.svh
`ifndef CONV_ARGS_DEFINES_SVH
`define CONV_ARGS_DEFINES_SVH

// argument memory geometry
`define ARGS_WORD_W 512
`define ARGS_ADR_W  16
`define ARGS_DEPTH  1024

// log2 of arguments packed in one 512-bit word
`define BIAS_PER_WORD_LOG2 6
`define TAIL_PER_WORD_LOG2 5
`define RANK_PER_WORD_LOG2 6

// output channels per tile
`define ROWS_MODE0 64
`define ROWS_MODE1 128

// log2 of arguments held by one downstream register
`define ARGS_PER_REG_LOG2_MODE0 0
`define ARGS_PER_REG_LOG2_MODE1 1

`define OF_W   16
`define SLOT_W 8

`endif

//--- design/conv_args_loader.sv
`default_nettype none
`include "conv_args_defines.svh"

module conv_args_loader
  import conv_args_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    args_refresh,
  input  wire layer_cfg_t              cfg_in,
  input  wire logic                    wr_en,
  input  wire logic [`ARGS_ADR_W-1:0]  wr_adr,
  input  wire logic [`ARGS_WORD_W-1:0] wr_data,
  output logic                         arg_valid,
  output arg_word_t                    arg_word,
  output logic                         busy,
  output logic                         tile_done,
  output logic                         layer_done
);

  layer_cfg_t              cfg;
  tile_t                   tile;
  logic                    tile_go;
  logic [2:0]              req;
  logic [2:0]              gnt;
  logic [2:0]              kind_done;
  mem_req_t                req_info [3];
  logic                    rd_en;
  logic [`ARGS_ADR_W-1:0]  rd_adr;
  logic [`ARGS_WORD_W-1:0] rd_data;

  ////////////////////////////////////////
  // tile control
  ////////////////////////////////////////

  args_tile_sequencer u_seq (
    .clk          (clk),
    .reset        (reset),
    .args_refresh (args_refresh),
    .cfg_in       (cfg_in),
    .kind_done    (kind_done),
    .cfg          (cfg),
    .tile         (tile),
    .tile_go      (tile_go),
    .busy         (busy),
    .tile_done    (tile_done),
    .layer_done   (layer_done)
  );

  ////////////////////////////////////////
  // per-kind fetchers
  ////////////////////////////////////////

  args_stream_fetch #(.KIND(KIND_BIAS), .PER_WORD_LOG2(`BIAS_PER_WORD_LOG2)) u_bias (
    .clk(clk), .reset(reset), .cfg(cfg), .tile(tile), .tile_go(tile_go),
    .gnt(gnt[KIND_BIAS]), .req(req[KIND_BIAS]), .req_info(req_info[KIND_BIAS]),
    .kind_done(kind_done[KIND_BIAS])
  );

  args_stream_fetch #(.KIND(KIND_TAIL), .PER_WORD_LOG2(`TAIL_PER_WORD_LOG2)) u_tail (
    .clk(clk), .reset(reset), .cfg(cfg), .tile(tile), .tile_go(tile_go),
    .gnt(gnt[KIND_TAIL]), .req(req[KIND_TAIL]), .req_info(req_info[KIND_TAIL]),
    .kind_done(kind_done[KIND_TAIL])
  );

  args_stream_fetch #(.KIND(KIND_RANK), .PER_WORD_LOG2(`RANK_PER_WORD_LOG2)) u_rank (
    .clk(clk), .reset(reset), .cfg(cfg), .tile(tile), .tile_go(tile_go),
    .gnt(gnt[KIND_RANK]), .req(req[KIND_RANK]), .req_info(req_info[KIND_RANK]),
    .kind_done(kind_done[KIND_RANK])
  );

  ////////////////////////////////////////
  // shared memory path
  ////////////////////////////////////////

  args_mem_arbiter u_arb (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .req_info  (req_info),
    .rd_data   (rd_data),
    .gnt       (gnt),
    .rd_en     (rd_en),
    .rd_adr    (rd_adr),
    .arg_valid (arg_valid),
    .arg_word  (arg_word)
  );

  args_word_ram u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_adr  (wr_adr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_adr  (rd_adr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- design/conv_args_pkg.sv
`default_nettype none
`include "conv_args_defines.svh"

package conv_args_pkg;

  // fetcher identity, also used as the read tag
  typedef enum logic [1:0] {
    KIND_BIAS = 2'd0,
    KIND_TAIL = 2'd1,
    KIND_RANK = 2'd2
  } args_kind_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_RUN,
    FETCH_DONE
  } fetch_state_e;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_BUSY
  } seq_state_e;

  typedef struct packed {
    logic                   mode;
    logic [`OF_W-1:0]       of;
    logic [`ARGS_ADR_W-1:0] bias_base;
    logic [`ARGS_ADR_W-1:0] tail_base;
    logic [`ARGS_ADR_W-1:0] rank_base;
  } layer_cfg_t;

  // tof_start is 0-based
  typedef struct packed {
    logic [`OF_W-1:0] tof_start;
    logic [`OF_W-1:0] tile_size;
  } tile_t;

  typedef struct packed {
    logic [`ARGS_ADR_W-1:0] adr;
    logic [`SLOT_W-1:0]     reg_start;
    logic [`SLOT_W-1:0]     reg_size;
  } mem_req_t;

  typedef struct packed {
    args_kind_e              kind;
    logic [`ARGS_ADR_W-1:0]  adr;
    logic [`SLOT_W-1:0]      reg_start;
    logic [`SLOT_W-1:0]      reg_size;
    logic [`ARGS_WORD_W-1:0] data;
  } arg_word_t;

endpackage

`default_nettype wire

//--- tb/conv_args_tb.sv
`default_nettype none
`include "conv_args_defines.svh"

module conv_args_tb
  import conv_args_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PRELOAD_WORDS = 128;
  localparam int TILE_TIMEOUT  = 400;
  localparam int QUIET_CYCLES  = 12;

  logic                    clk;
  logic                    reset;
  logic                    args_refresh;
  layer_cfg_t              cfg_in;
  logic                    wr_en;
  logic [`ARGS_ADR_W-1:0]  wr_adr;
  logic [`ARGS_WORD_W-1:0] wr_data;
  logic                    arg_valid;
  arg_word_t               arg_word;
  logic                    busy;
  logic                    tile_done;
  logic                    layer_done;

  logic [`ARGS_WORD_W-1:0] shadow [`ARGS_DEPTH];
  arg_word_t               exp_q [3][$];
  arg_word_t               got_q [3][$];
  logic [31:0]             lcg_state;

  conv_args_loader DUT (
    .clk          (clk),
    .reset        (reset),
    .args_refresh (args_refresh),
    .cfg_in       (cfg_in),
    .wr_en        (wr_en),
    .wr_adr       (wr_adr),
    .wr_data      (wr_data),
    .arg_valid    (arg_valid),
    .arg_word     (arg_word),
    .busy         (busy),
    .tile_done    (tile_done),
    .layer_done   (layer_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_arg_word(input string name, input arg_word_t exp, input arg_word_t got);
    if (got !== exp)
    begin
      fail_run($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
    end
  endtask

  task automatic check_kind(input string name, input args_kind_e exp, input args_kind_e got);
    if (got !== exp)
    begin
      fail_run($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit got);
    if (got !== exp)
    begin
      fail_run($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp)
    begin
      fail_run($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
    end
  endtask

  function automatic layer_cfg_t make_cfg(input bit mode, input int of,
                                          input int b, input int t, input int r);
    layer_cfg_t c;
    c.mode      = mode;
    c.of        = `OF_W'(of);
    c.bias_base = `ARGS_ADR_W'(b);
    c.tail_base = `ARGS_ADR_W'(t);
    c.rank_base = `ARGS_ADR_W'(r);
    return c;
  endfunction

  function automatic int per_word_log2(input args_kind_e k);
    case (k)
      KIND_TAIL: return `TAIL_PER_WORD_LOG2;
      KIND_RANK: return `RANK_PER_WORD_LOG2;
      default:   return `BIAS_PER_WORD_LOG2;
    endcase
  endfunction

  function automatic logic [`ARGS_ADR_W-1:0] base_of(input layer_cfg_t c, input args_kind_e k);
    case (k)
      KIND_TAIL: return c.tail_base;
      KIND_RANK: return c.rank_base;
      default:   return c.bias_base;
    endcase
  endfunction

  function automatic int rows_of(input layer_cfg_t c);
    return c.mode ? `ROWS_MODE1 : `ROWS_MODE0;
  endfunction

  // each 32-bit lane mixes the LCG with the full address
  task automatic preload(input int n);
    logic [`ARGS_WORD_W-1:0] w;
    for (int a = 0; a < n; a++)
    begin
      for (int l = 0; l < `ARGS_WORD_W / 32; l++)
      begin
        w[l*32 +: 32] = lcg_next() ^ {16'(a), 16'(l)};
      end
      @(negedge clk);
      wr_en     = 1'b1;
      wr_adr    = `ARGS_ADR_W'(a);
      wr_data   = w;
      shadow[a] = w;
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  task automatic build_expected(input layer_cfg_t c, input int tof, input int size);
    args_kind_e  k;
    int          lg;
    int          per_word;
    int          n_words;
    int          args_n;
    int          shift;
    logic [7:0]  start;
    arg_word_t   w;
    shift = c.mode ? `ARGS_PER_REG_LOG2_MODE1 : `ARGS_PER_REG_LOG2_MODE0;
    for (int ki = 0; ki < 3; ki++)
    begin
      k        = args_kind_e'(ki);
      lg       = per_word_log2(k);
      per_word = 1 << lg;
      n_words  = (size + per_word - 1) / per_word;
      start    = '0;
      exp_q[ki].delete();
      for (int i = 0; i < n_words; i++)
      begin
        args_n      = size - i * per_word;
        args_n      = (args_n > per_word) ? per_word : args_n;
        w.kind      = k;
        w.adr       = base_of(c, k) + `ARGS_ADR_W'(tof >> lg) + `ARGS_ADR_W'(i);
        w.reg_start = start;
        w.reg_size  = 8'(args_n >> shift);
        w.data      = shadow[w.adr[9:0]];
        exp_q[ki].push_back(w);
        start = start + w.reg_size;
      end
    end
  endtask

  // kind whose expected words hold this address, -1 if none
  function automatic int kind_of_adr(input logic [`ARGS_ADR_W-1:0] adr);
    for (int ki = 0; ki < 3; ki++)
    begin
      for (int i = 0; i < exp_q[ki].size(); i++)
      begin
        if (exp_q[ki][i].adr == adr)
        begin
          return ki;
        end
      end
    end
    return -1;
  endfunction

  task automatic collect_word(input arg_word_t w);
    int ki;
    ki = kind_of_adr(w.adr);
    if (ki < 0)
    begin
      fail_run($sformatf("arg_word address %h matches no expected word", w.adr));
    end
    check_kind("arg_word.kind", args_kind_e'(ki), w.kind);
    got_q[ki].push_back(w);
  endtask

  // per-kind order is fixed, interleaving between kinds is not
  task automatic compare_queues();
    args_kind_e k;
    for (int ki = 0; ki < 3; ki++)
    begin
      k = args_kind_e'(ki);
      check_count($sformatf("%s word count", k.name()), exp_q[ki].size(), got_q[ki].size());
      for (int i = 0; i < exp_q[ki].size(); i++)
      begin
        check_arg_word($sformatf("arg_word %s #%0d", k.name(), i), exp_q[ki][i], got_q[ki][i]);
      end
    end
  endtask

  task automatic watch_quiet(input int n);
    repeat (n)
    begin
      @(negedge clk);
      check_flag("arg_valid", 1'b0, arg_valid);
      check_flag("tile_done", 1'b0, tile_done);
      check_flag("layer_done", 1'b0, layer_done);
    end
    check_flag("busy", 1'b0, busy);
  endtask

  ////////////////////////////////////////
  // tile and layer runs
  ////////////////////////////////////////

  task automatic run_tile(input layer_cfg_t c, input int tof, input bit last,
                          input bit extra_refresh);
    int cycles;
    bit done;
    bit layer_seen;
    bit refresh_sent;
    int size;
    size = int'(c.of) - tof;
    size = (size < rows_of(c)) ? size : rows_of(c);
    build_expected(c, tof, size);
    for (int ki = 0; ki < 3; ki++)
    begin
      got_q[ki].delete();
    end
    @(negedge clk);
    cfg_in       = c;
    args_refresh = 1'b1;
    @(negedge clk);
    args_refresh = 1'b0;
    cycles       = 0;
    done         = 1'b0;
    layer_seen   = 1'b0;
    refresh_sent = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      cycles++;
      if (arg_valid)
      begin
        collect_word(arg_word);
      end
      if (tile_done)
      begin
        done       = 1'b1;
        layer_seen = layer_done;
      end
      else if (layer_done)
      begin
        fail_run("layer_done pulsed without tile_done");
      end
      if (!done && cycles >= TILE_TIMEOUT)
      begin
        fail_run("timed out waiting for tile_done");
      end
      // second refresh once bias has finished and the tile still runs
      if (extra_refresh && !refresh_sent && !done
          && got_q[int'(KIND_BIAS)].size() == exp_q[int'(KIND_BIAS)].size())
      begin
        check_flag("busy", 1'b1, busy);
        args_refresh = 1'b1;
        refresh_sent = 1'b1;
      end
      else
      begin
        args_refresh = 1'b0;
      end
    end
    args_refresh = 1'b0;
    if (extra_refresh && !refresh_sent)
    begin
      fail_run("extra refresh was never issued during the tile");
    end
    watch_quiet(QUIET_CYCLES);
    check_flag("layer_done", last, layer_seen);
    compare_queues();
  endtask

  task automatic run_layer(input layer_cfg_t c);
    int tof;
    bit last;
    tof  = 0;
    last = 1'b0;
    while (!last)
    begin
      last = (tof + rows_of(c)) >= int'(c.of);
      run_tile(c, tof, last, 1'b0);
      tof = tof + rows_of(c);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_quiet();
    check_flag("arg_valid", 1'b0, arg_valid);
    check_flag("busy", 1'b0, busy);
    check_flag("tile_done", 1'b0, tile_done);
    check_flag("layer_done", 1'b0, layer_done);
    watch_quiet(20);
  endtask

  // one bias, two tail and one rank word
  task automatic test_mode0_full();
    run_tile(make_cfg(1'b0, 64, 0, 8, 16), 0, 1'b1, 1'b0);
  endtask

  // 200 channels leave 72 for the second tile
  task automatic test_mode1_partial();
    run_layer(make_cfg(1'b1, 200, 32, 40, 56));
  endtask

  task automatic test_layer_wrap();
    run_layer(make_cfg(1'b0, 100, 64, 72, 80));
    run_tile(make_cfg(1'b1, 128, 96, 104, 112), 0, 1'b1, 1'b0);
  endtask

  task automatic test_refresh_busy();
    run_tile(make_cfg(1'b1, 128, 4, 20, 48), 0, 1'b1, 1'b1);
  endtask

  task automatic test_contention();
    run_layer(make_cfg(1'b1, 256, 0, 10, 30));
  endtask

  initial
  begin
    reset        = 1'b1;
    args_refresh = 1'b0;
    cfg_in       = '0;
    wr_en        = 1'b0;
    wr_adr       = '0;
    wr_data      = '0;
    lcg_state    = 32'd68599;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    test_reset_quiet();
    preload(PRELOAD_WORDS);
    test_mode0_full();
    test_mode1_partial();
    test_layer_wrap();
    test_refresh_busy();
    test_contention();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
